// File: flist.f
mdu_pkg.sv
mdu_if.sv
mdu_req_ctrl.sv
mdu_mul.sv
mdu_div.sv
mdu_top.sv
mdu_chk.sv
tb_mdu.sv

// File: mdu_chk.sv
/*
 * Handshake and engine start checks, bound into the request controller
 */
module mdu_chk (
    input logic g_clk,
    input logic rst,
    input logic flush,
    input logic req,
    input logic ack,
    input logic mul_start,
    input logic div_start
);

    // ----------------------------------------
    // Four-phase req/ack
    // ----------------------------------------

    assert property (@(posedge g_clk) disable iff (rst || flush) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    assert property (@(posedge g_clk) disable iff (rst || flush) (ack && req) |=> ack)
        else $error("ack fell before req was released");

    // Engine launch pulses
    assert property (@(posedge g_clk) disable iff (rst) mul_start |=> !mul_start)
        else $error("multiplier start longer than one cycle");

    assert property (@(posedge g_clk) disable iff (rst) div_start |=> !div_start)
        else $error("divider start longer than one cycle");

    assert property (@(posedge g_clk) disable iff (rst) !(mul_start && div_start))
        else $error("start sent to both engines at once");

endmodule

bind mdu_req_ctrl mdu_chk u_chk (
    .g_clk     (g_clk),
    .rst       (rst),
    .flush     (flush),
    .req       (req),
    .ack       (ack),
    .mul_start (mul_port.start),
    .div_start (div_port.start)
);

// File: mdu_div.sv
/*
 * Iterative restoring divider
 * One quotient bit per cycle on operand magnitudes, sign fix-up at the
 * end, word mode sign-extended from bit 31
 */
module mdu_div
    import mdu_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic  g_clk,
    input  logic  rst,
    input  logic  flush,
    mdu_if.engine port
);

    localparam int WORD = 32;
    localparam int CW   = $clog2(XLEN + 1);

    logic              busy;
    logic [CW-1:0]     cnt;
    logic [XLEN-1:0]   rem;         // Running remainder magnitude
    logic [XLEN-1:0]   quo;         // Quotient bits shift in at bit 0
    logic [2*XLEN-1:0] dvs;         // Divisor, walks down one bit per cycle
    logic              neg_q;       // Negate the final result
    logic              rem_q;
    logic              word_q;
    logic              ge;

    // Start-time operand handling
    logic              sgn;
    logic              sa;
    logic              sb;
    logic              b_nz;
    logic [XLEN-1:0]   a_ext;
    logic [XLEN-1:0]   b_ext;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;

    // Result path
    logic [XLEN-1:0]   pre;
    logic [XLEN-1:0]   fix;

    // ----------------------------------------
    // Operand magnitudes
    // ----------------------------------------

    assign sgn   = is_div_signed(port.op);
    assign sa    = sgn && (port.op_word ? port.a[WORD-1] : port.a[XLEN-1]);
    assign sb    = sgn && (port.op_word ? port.b[WORD-1] : port.b[XLEN-1]);
    assign b_nz  = port.op_word ? |port.b[WORD-1:0] : |port.b;

    // Word operands re-extended to full width first
    assign a_ext = port.op_word ? {{(XLEN-WORD){sa}}, port.a[WORD-1:0]} : port.a;
    assign b_ext = port.op_word ? {{(XLEN-WORD){sb}}, port.b[WORD-1:0]} : port.b;
    assign mag_a = sa ? -a_ext : a_ext;
    assign mag_b = sb ? -b_ext : b_ext;     // Most negative value stays correct unsigned

    assign ge    = dvs <= {{XLEN{1'b0}}, rem};  // Zero divisor always fits

    // ----------------------------------------
    // Control
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            busy      <= 1'b0;
            cnt       <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (!busy && port.start) begin
                busy <= 1'b1;
                cnt  <= port.op_word ? CW'(WORD) : CW'(XLEN);
            end else if (busy) begin
                cnt <= cnt - CW'(1);
                if (cnt == CW'(1)) begin
                    busy      <= 1'b0;
                    port.done <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (!busy && port.start) begin
            rem    <= mag_a;
            quo    <= '0;
            // First compare weighs the divisor at the top quotient bit
            dvs    <= {{XLEN{1'b0}}, mag_b} << (port.op_word ? WORD - 1 : XLEN - 1);
            rem_q  <= is_rem(port.op);
            word_q <= port.op_word;
            if (is_rem(port.op)) begin
                neg_q <= sa;                    // Remainder follows dividend
            end else begin
                neg_q <= (sa != sb) && b_nz;    // Div by zero stays all ones
            end
        end else if (busy) begin
            if (ge) begin
                rem <= rem - dvs[XLEN-1:0];
            end
            quo <= {quo[XLEN-2:0], ge};
            dvs <= dvs >> 1;
        end
    end

    // Sign fix-up and word extension
    assign pre         = rem_q ? rem : quo;
    assign fix         = neg_q ? -pre : pre;
    assign port.result = word_q ? {{(XLEN-WORD){fix[WORD-1]}}, fix[WORD-1:0]} : fix;

endmodule

// File: mdu_if.sv
/*
 * Controller to arithmetic engine link
 * start/done pulses, opcode, operands and result
 */
interface mdu_if
    import mdu_pkg::*;
#(
    parameter int XLEN = 64
) ();

    // Controller side
    logic            start;     // One-cycle launch pulse
    mdu_op_e         op;
    logic            op_word;   // Work on low 32 bits
    logic [XLEN-1:0] a;         // rs1
    logic [XLEN-1:0] b;         // rs2

    // Engine side
    logic            done;      // One-cycle finish pulse
    logic [XLEN-1:0] result;    // Valid together with done

    // Operands are sampled by the engine on start only
    modport ctrl (
        output start,
        output op,
        output op_word,
        output a,
        output b,
        input  done,
        input  result
    );

    modport engine (
        input  start,
        input  op,
        input  op_word,
        input  a,
        input  b,
        output done,
        output result
    );

endinterface

// File: mdu_mul.sv
/*
 * Iterative shift-add multiplier
 * MUL_UNROLL multiplier bits per cycle, signed and unsigned high halves,
 * sign-extended word results
 */
module mdu_mul
    import mdu_pkg::*;
#(
    parameter int XLEN       = 64,
    parameter int MUL_UNROLL = 4     // 1, 2, 4 or 8
) (
    input  logic  g_clk,
    input  logic  rst,
    input  logic  flush,
    mdu_if.engine port
);

    localparam int FULL_STEPS = XLEN / MUL_UNROLL;
    localparam int WORD_STEPS = 32 / MUL_UNROLL;
    localparam int CW         = $clog2(FULL_STEPS + 1);

    logic              busy;
    logic [CW-1:0]     cnt;         // Steps still to run
    logic [2*XLEN-1:0] acc;         // Product, shifts right each bit
    logic [2*XLEN-1:0] acc_nxt;
    logic [XLEN-1:0]   mcand;
    logic [XLEN-1:0]   mplier;      // Consumed from bit 0
    logic [XLEN-1:0]   mplier_nxt;
    mdu_op_e           op_q;
    logic              word_q;
    logic              a_signed;
    logic              b_signed;

    // Partial product datapath
    logic [XLEN-1:0]   addend;
    logic [XLEN:0]     hi;
    logic [XLEN:0]     ext_add;
    logic [XLEN:0]     sum;
    logic              sub_step;

    // Word mode only needs the low 32 product bits, so unsigned is fine
    assign a_signed = !word_q && mul_rs1_signed(op_q);
    assign b_signed = !word_q && (op_q == OP_MULH);

    // ----------------------------------------
    // One cycle of MUL_UNROLL steps
    // ----------------------------------------

    always_comb begin
        acc_nxt    = acc;
        mplier_nxt = mplier;
        addend     = '0;
        hi         = '0;
        ext_add    = '0;
        sum        = '0;
        sub_step   = 1'b0;
        for (int i = 0; i < MUL_UNROLL; i++) begin
            // Top bit of a signed multiplier weighs negative
            sub_step   = b_signed && (cnt == CW'(1)) && (i == MUL_UNROLL - 1);
            addend     = mplier_nxt[0] ? mcand : '0;
            hi         = {a_signed && acc_nxt[2*XLEN-1], acc_nxt[2*XLEN-1:XLEN]};
            ext_add    = {a_signed && addend[XLEN-1], addend};
            sum        = sub_step ? hi - ext_add : hi + ext_add;
            acc_nxt    = {sum, acc_nxt[XLEN-1:1]};
            mplier_nxt = mplier_nxt >> 1;
        end
    end

    // ----------------------------------------
    // Control
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            busy      <= 1'b0;
            cnt       <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (!busy && port.start) begin      // start ignored while busy
                busy <= 1'b1;
                cnt  <= port.op_word ? CW'(WORD_STEPS) : CW'(FULL_STEPS);
            end else if (busy) begin
                cnt <= cnt - CW'(1);
                if (cnt == CW'(1)) begin
                    busy      <= 1'b0;
                    port.done <= 1'b1;          // acc final at the same edge
                end
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!busy && port.start) begin
            acc    <= '0;
            mcand  <= port.a;
            mplier <= port.b;
            op_q   <= port.op;
            word_q <= port.op_word;
        end else if (busy) begin
            acc    <= acc_nxt;
            mplier <= mplier_nxt;
        end
    end

    // Result select
    always_comb begin
        if (word_q) begin
            // Low 32 product bits sit just below the high half
            port.result = {{(XLEN-32){acc[XLEN-1]}}, acc[XLEN-1 -: 32]};
        end else if (is_mul_hi(op_q)) begin
            port.result = acc[2*XLEN-1:XLEN];
        end else begin
            port.result = acc[XLEN-1:0];
        end
    end

endmodule

// File: mdu_pkg.sv
/*
 * Shared types for the multiply/divide unit
 * Opcode and controller-state enums, opcode classification functions
 */
package mdu_pkg;

    // M-extension operations
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } mdu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // Waiting for a new req
        ST_BUSY  = 2'd1,    // Engine running
        ST_ACK   = 2'd2,    // Result held, ack high
        ST_DRAIN = 2'd3     // req has dropped, ack falls next
    } ctrl_state_e;

    // ----------------------------------------
    // Opcode classes
    // ----------------------------------------

    function automatic logic is_mul(input mdu_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic is_mul_hi(input mdu_op_e op);
        return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic mul_rs1_signed(input mdu_op_e op);
        return op inside {OP_MULH, OP_MULHSU};  // rs2 signed only for MULH
    endfunction

    function automatic logic is_div_signed(input mdu_op_e op);
        return op inside {OP_DIV, OP_REM};
    endfunction

    function automatic logic is_rem(input mdu_op_e op);
        return op inside {OP_REM, OP_REMU};
    endfunction

endpackage

// File: mdu_req_ctrl.sv
/*
 * Request controller
 * Four-phase req/ack FSM, operand capture, engine dispatch, result hold
 */
module mdu_req_ctrl
    import mdu_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            req,
    input  mdu_op_e         op,
    input  logic            op_word,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    output logic            ack,
    output logic [XLEN-1:0] rd,
    mdu_if.ctrl             mul_port,
    mdu_if.ctrl             div_port
);

    ctrl_state_e     state;
    logic            req_q;         // req one cycle ago
    logic            req_rise;
    logic            sel_mul;       // Engine owning the current op
    logic            eng_done;
    logic [XLEN-1:0] eng_result;
    mdu_op_e         op_q;
    logic            word_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;

    assign req_rise   = req && !req_q;
    assign eng_done   = sel_mul ? mul_port.done   : div_port.done;
    assign eng_result = sel_mul ? mul_port.result : div_port.result;

    // Both engines share one set of operand registers
    assign mul_port.op      = op_q;
    assign mul_port.op_word = word_q;
    assign mul_port.a       = a_q;
    assign mul_port.b       = b_q;
    assign div_port.op      = op_q;
    assign div_port.op_word = word_q;
    assign div_port.a       = a_q;
    assign div_port.b       = b_q;

    // ----------------------------------------
    // Edge detect, tracks req through flush
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req;   // A req held across flush is not a new one
        end
    end

    // ----------------------------------------
    // Operand and result registers
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (state == ST_IDLE && req_rise) begin
            op_q   <= op;
            word_q <= op_word;
            a_q    <= rs1;
            b_q    <= rs2;
        end
        if (state == ST_BUSY && eng_done) begin
            rd <= eng_result;       // Held until the next op
        end
    end

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            state          <= ST_IDLE;
            ack            <= 1'b0;
            sel_mul        <= 1'b0;
            mul_port.start <= 1'b0;
            div_port.start <= 1'b0;
        end else begin
            mul_port.start <= 1'b0;     // Pulses last one cycle
            div_port.start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_rise) begin
                        state          <= ST_BUSY;
                        sel_mul        <= is_mul(op);
                        mul_port.start <= is_mul(op);
                        div_port.start <= !is_mul(op);
                    end
                end
                ST_BUSY: begin
                    if (eng_done) begin
                        state <= ST_ACK;
                        ack   <= 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!req) state <= ST_DRAIN;  // Requester has seen ack
                end
                ST_DRAIN: begin
                    state <= ST_IDLE;
                    ack   <= 1'b0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: mdu_top.sv
/*
 * Multiply/divide unit top level
 * Request controller plus multiplier and divider engines
 */
module mdu_top
    import mdu_pkg::*;
#(
    parameter int XLEN       = 64,
    parameter int MUL_UNROLL = 4
) (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            flush,      // Abort any op in flight
    input  logic            req,
    input  mdu_op_e         op,
    input  logic            op_word,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    output logic            ack,
    output logic [XLEN-1:0] rd          // Valid while ack is high
);

    // One link per engine
    mdu_if #(.XLEN(XLEN)) mul_bus ();
    mdu_if #(.XLEN(XLEN)) div_bus ();

    mdu_req_ctrl #(
        .XLEN       (XLEN)
    ) u_req_ctrl (
        .g_clk      (g_clk),
        .rst        (rst),
        .flush      (flush),
        .req        (req),
        .op         (op),
        .op_word    (op_word),
        .rs1        (rs1),
        .rs2        (rs2),
        .ack        (ack),
        .rd         (rd),
        .mul_port   (mul_bus.ctrl),
        .div_port   (div_bus.ctrl)
    );

    mdu_mul #(
        .XLEN       (XLEN),
        .MUL_UNROLL (MUL_UNROLL)
    ) u_mul (
        .g_clk      (g_clk),
        .rst        (rst),
        .flush      (flush),
        .port       (mul_bus.engine)
    );

    mdu_div #(
        .XLEN       (XLEN)
    ) u_div (
        .g_clk      (g_clk),
        .rst        (rst),
        .flush      (flush),
        .port       (div_bus.engine)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build tb_mdu with Verilator, run it, then judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mdu -f flist.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_mdu > sim.log 2>&1 || true
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

// File: tb_mdu.sv
/*
 * Directed testbench for the multiply/divide unit
 * Clock, reset, four-phase handshake task, 128-bit reference model
 */
module tb_mdu
    import mdu_pkg::*;
();

    localparam int          XLEN    = 64;
    localparam int          TIMEOUT = 300;      // Cycles allowed per wait
    localparam logic [31:0] SEED    = 32'h5a25_6674;

    logic            g_clk;
    logic            rst;
    logic            flush;
    logic            req;
    mdu_op_e         op;
    logic            op_word;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            ack;
    logic [XLEN-1:0] rd;

    // Zero, one, -1 and both signed extremes
    logic [63:0] corners [5] = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000,
                                 64'h7fff_ffff_ffff_ffff};

    mdu_top #(.XLEN(XLEN), .MUL_UNROLL(4)) u_mdu_top (
        .g_clk(g_clk), .rst(rst), .flush(flush), .req(req), .op(op),
        .op_word(op_word), .rs1(rs1), .rs2(rs2), .ack(ack), .rd(rd)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1, "Wait loop exceeded its limit");
    endtask

    task automatic fail_now(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopping on first error");
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // RISC-V M rules on 128-bit values and word mode on the low 32 bits
    function automatic logic [63:0] ref_result(input mdu_op_e o, input logic w,
                                               input logic [63:0] a, input logic [63:0] b);
        int                  n;
        logic [127:0]        za;
        logic [127:0]        zb;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic [127:0]        r;
        n  = w ? 32 : 64;
        za = w ? {96'd0, a[31:0]} : {64'd0, a};
        zb = w ? {96'd0, b[31:0]} : {64'd0, b};
        sa = w ? {{96{a[31]}}, a[31:0]} : {{64{a[63]}}, a};
        sb = w ? {{96{b[31]}}, b[31:0]} : {{64{b[63]}}, b};
        case (o)
            OP_MUL:    r = za * zb;
            OP_MULH:   r = (sa * sb) >> n;
            OP_MULHSU: r = (sa * zb) >> n;
            OP_MULHU:  r = (za * zb) >> n;
            OP_DIV: begin
                if (zb == 0) r = '1;            // Divide by zero gives all ones
                else r = sa / sb;               // Overflow wraps to most negative
            end
            OP_DIVU: begin
                if (zb == 0) r = '1;
                else r = za / zb;
            end
            OP_REM: begin
                if (zb == 0) r = sa;            // Remainder is the dividend
                else r = sa % sb;
            end
            default: begin
                if (zb == 0) r = za;
                else r = za % zb;
            end
        endcase
        return w ? {{32{r[31]}}, r[31:0]} : r[63:0];
    endfunction

    // Full four-phase cycle with req held for hold extra cycles after ack
    task automatic do_op(input mdu_op_e o, input logic w, input logic [63:0] a,
                         input logic [63:0] b, input int hold, output logic [63:0] res);
        int n;
        @(posedge g_clk);
        op      <= o;
        op_word <= w;
        rs1     <= a;
        rs2     <= b;
        req     <= 1'b1;
        n = 0;
        while (!ack) begin
            @(posedge g_clk);
            n++;
            if (n > TIMEOUT) report_timeout("ack to rise");
        end
        res = rd;
        for (int i = 0; i < hold; i++) begin
            @(posedge g_clk);
            assert (ack === 1'b1 && rd === res) else
                fail_now($sformatf("ack %b rd %h changed under back-pressure, held %h",
                                   ack, rd, res));
        end
        req <= 1'b0;
        n = 0;
        while (ack) begin
            @(posedge g_clk);
            n++;
            if (n > TIMEOUT) report_timeout("ack to fall");
        end
    endtask

    task automatic run_and_check(input mdu_op_e o, input logic w, input logic [63:0] a,
                                 input logic [63:0] b, input int hold);
        logic [63:0] got;
        logic [63:0] exp;
        exp = ref_result(o, w, a, b);
        do_op(o, w, a, b, hold, got);
        assert (got === exp) else
            fail_now($sformatf("%s word=%b a=%h b=%h expected %h got %h",
                               o.name(), w, a, b, exp, got));
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_full_width(input int first_op);
        mdu_op_e o;
        for (int k = first_op; k < first_op + 4; k++) begin
            o = mdu_op_e'(k);
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    run_and_check(o, 1'b0, corners[i], corners[j], 0);
                end
            end
            repeat (10) run_and_check(o, 1'b0, rand64(), rand64(), 0);
        end
    endtask

    task automatic test_word_mode();
        mdu_op_e     word_ops [5] = '{OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        logic [63:0] wc [5] = '{64'd0, 64'd1, 64'hffff_ffff, 64'h8000_0000, 64'h7fff_ffff};
        logic [63:0] junk;
        foreach (word_ops[k]) begin
            foreach (wc[i]) begin
                foreach (wc[j]) begin
                    junk = rand64() & 64'hffff_ffff_0000_0000;  // Upper bits must not matter
                    run_and_check(word_ops[k], 1'b1, wc[i] | junk, wc[j], 0);
                end
            end
            repeat (10) run_and_check(word_ops[k], 1'b1, rand64(), rand64(), 0);
        end
    endtask

    task automatic test_back_pressure();
        repeat (12) begin
            run_and_check(mdu_op_e'($urandom_range(7, 0)), 1'b0, rand64(), rand64(),
                          $urandom_range(20, 1));
        end
    endtask

    task automatic test_flush();
        @(posedge g_clk);
        op      <= OP_DIV;
        op_word <= 1'b0;
        rs1     <= rand64();
        rs2     <= rand64();
        req     <= 1'b1;
        repeat (20) @(posedge g_clk);       // Divider still mid-way
        flush <= 1'b1;
        req   <= 1'b0;
        @(posedge g_clk);
        flush <= 1'b0;
        repeat (80) begin
            @(posedge g_clk);
            assert (ack === 1'b0) else fail_now("ack high after flush");
        end
        run_and_check(OP_MULHSU, 1'b0, rand64(), rand64(), 0);
    endtask

    task automatic test_random_stream();
        mdu_op_e     o;
        logic        w;
        logic [63:0] a;
        logic [63:0] b;
        repeat (200) begin
            o = mdu_op_e'($urandom_range(7, 0));
            w = is_mul_hi(o) ? 1'b0 : 1'($urandom_range(1, 0));  // No word high-half ops
            a = ($urandom_range(7, 0) == 0) ? corners[$urandom_range(4, 0)] : rand64();
            b = ($urandom_range(7, 0) == 0) ? corners[$urandom_range(4, 0)] : rand64();
            run_and_check(o, w, a, b, 0);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst     = 1'b1;
        flush   = 1'b0;
        req     = 1'b0;
        op      = OP_MUL;
        op_word = 1'b0;
        rs1     = '0;
        rs2     = '0;
        repeat (4) @(posedge g_clk);
        rst <= 1'b0;
        test_full_width(0);     // Multiplies
        test_full_width(4);     // Divides and remainders
        test_word_mode();
        test_back_pressure();
        test_flush();
        test_random_stream();
        $display("Test completed successfully");
        $finish;
    end

endmodule
